// File: filelist.f
+incdir+testbench
src/audio_pkg.sv
src/sample_if.sv
src/tone_source.sv
src/lowpass_fir.sv
src/audio_pipeline.sv
testbench/audio_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the audio pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing -Wno-fatal \
  --top-module audio_pipeline_tb \
  -f filelist.f \
  -o audio_pipeline_sim

./obj_dir/audio_pipeline_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: src/audio_pipeline.sv
`timescale 1ns/1ns

// audio sample path, top level
// stage 1 picks mic or tone, stage 2 filters or bypasses
// strobe to out_valid is a fixed pipeline_latency cycles
module audio_pipeline
  import audio_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  // sample capture
  input  logic           sample_ready,
  input  sample_t        mic_data,
  // mode controls
  input  logic           playback,
  input  logic           filter,
  // result
  output logic           out_valid,
  output sample_t        out_data,
  output sample_source_t out_source
);

  //////////////////////////////////////////////////////////////////////
  // stage link
  //////////////////////////////////////////////////////////////////////

  // tagged sample from stage 1 to stage 2
  sample_if stage_link ();

  //////////////////////////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////////////////////////

  // source select, mic loopback or tone table
  tone_source u_tone_source (
    .clock        (clock),
    .reset        (reset),
    .sample_ready (sample_ready),
    .mic_data     (mic_data),
    .playback     (playback),
    .filter       (filter),
    .out          (stage_link)
  );

  // low-pass filter with per-sample bypass
  lowpass_fir u_lowpass_fir (
    .clock      (clock),
    .reset      (reset),
    .in         (stage_link),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_source (out_source)
  );

endmodule

// File: src/audio_pkg.sv
package audio_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample format
  //////////////////////////////////////////////////////////////////////

  // 8-bit signed audio, same width for mic and tone
  localparam int sample_width = 8;

  typedef logic signed [sample_width-1:0] sample_t;

  // where a sample came from, tagged along the pipeline
  typedef enum logic {
    SOURCE_MIC,
    SOURCE_TONE
  } sample_source_t;

  //////////////////////////////////////////////////////////////////////
  // tone generator
  //////////////////////////////////////////////////////////////////////

  localparam int tone_points      = 64;
  localparam int tone_index_width = 6;

  // one sine period, top byte of each 20-bit point
  // starts at zero and rises, peak at entry 16, trough at entry 48
  localparam sample_t tone_table [0:tone_points-1] = '{
    8'sh00, 8'sh0C, 8'sh18, 8'sh25, 8'sh30, 8'sh3C, 8'sh47, 8'sh51,
    8'sh5A, 8'sh62, 8'sh6A, 8'sh70, 8'sh76, 8'sh7A, 8'sh7D, 8'sh7F,
    8'sh7F, 8'sh7F, 8'sh7D, 8'sh7A, 8'sh76, 8'sh70, 8'sh6A, 8'sh62,
    8'sh5A, 8'sh51, 8'sh47, 8'sh3C, 8'sh30, 8'sh25, 8'sh18, 8'sh0C,
    8'sh00, 8'shF3, 8'shE7, 8'shDA, 8'shCF, 8'shC3, 8'shB8, 8'shAE,
    8'shA5, 8'sh9D, 8'sh95, 8'sh8F, 8'sh89, 8'sh85, 8'sh82, 8'sh80,
    8'sh80, 8'sh80, 8'sh82, 8'sh85, 8'sh89, 8'sh8F, 8'sh95, 8'sh9D,
    8'shA5, 8'shAE, 8'shB8, 8'shC3, 8'shCF, 8'shDA, 8'shE7, 8'shF3
  };

  //////////////////////////////////////////////////////////////////////
  // low-pass FIR
  //////////////////////////////////////////////////////////////////////

  localparam int fir_taps        = 31;
  localparam int tap_index_width = 5;
  // ring is one deeper than the tap count
  localparam int history_depth   = 32;

  localparam int coeff_width = 10;

  typedef logic signed [coeff_width-1:0] coeff_t;

  // coefficients scaled by 2**acc_shift
  localparam int acc_width = 18;
  localparam int acc_shift = 10;

  typedef logic signed [acc_width-1:0] acc_t;

  // symmetric about tap 15, peak of 128
  localparam coeff_t fir_coeffs [0:fir_taps-1] = '{
    -10'sd1,  -10'sd1,  -10'sd3,  -10'sd5,
    -10'sd6,  -10'sd7,  -10'sd5,  10'sd0,
    10'sd10,  10'sd26,  10'sd46,  10'sd69,
    10'sd91,  10'sd110, 10'sd123, 10'sd128,
    10'sd123, 10'sd110, 10'sd91,  10'sd69,
    10'sd46,  10'sd26,  10'sd10,  10'sd0,
    -10'sd5,  -10'sd7,  -10'sd6,  -10'sd5,
    -10'sd3,  -10'sd1,  -10'sd1
  };

  // fir sequencer states
  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_ACCUMULATE,
    FIR_EMIT
  } fir_state_t;

  //////////////////////////////////////////////////////////////////////
  // pipeline timing
  //////////////////////////////////////////////////////////////////////

  // accept, 31 taps, then the result register
  localparam int fir_cycles = 32;

  // one extra cycle for the stage 1 register
  localparam int pipeline_latency = fir_cycles + 1;

  // gap between strobes so the fir is idle again
  localparam int min_strobe_spacing = 34;

endpackage

// File: src/lowpass_fir.sv
`timescale 1ns/1ns

// stage 2 of the audio pipeline
// sequential 31-tap low-pass FIR, one multiply-accumulate per clock
// bypassed samples take the same path so timing never changes
module lowpass_fir
  import audio_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  sample_if.sink         in,
  output logic           out_valid,
  output sample_t        out_data,
  output sample_source_t out_source
);

  //////////////////////////////////////////////////////////////////////
  // state and storage
  //////////////////////////////////////////////////////////////////////

  fir_state_t state;

  // ring of past samples, newest at write_offset - 1
  sample_t history [0:history_depth-1];
  logic [tap_index_width-1:0] write_offset;

  // current tap, also the age of the sample it reads
  logic [tap_index_width-1:0] tap;
  logic [tap_index_width-1:0] read_addr;

  acc_t acc;
  acc_t product;

  // tags and raw value of the sample being worked on
  sample_t        raw_sample;
  logic           filter_on;
  sample_source_t held_source;

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // sample tap steps older than the newest one
  assign read_addr = write_offset - tap - tap_index_width'(1);

  // signed product, sized to the accumulator
  assign product = history[read_addr] * fir_coeffs[tap];

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= FIR_IDLE;
      write_offset <= '0;
      tap          <= '0;
      acc          <= '0;
      out_valid    <= 1'b0;
      out_data     <= '0;
      out_source   <= SOURCE_MIC;
      // history restarts from silence
      for (int i = 0; i < history_depth; i++) begin
        history[i] <= '0;
      end
    end else begin
      // strobe is high for one cycle only
      out_valid <= 1'b0;

      case (state)
        FIR_IDLE: begin
          if (in.valid) begin
            // every sample enters the history, filtered or not
            history[write_offset] <= in.data;
            write_offset          <= write_offset + tap_index_width'(1);
            acc                   <= '0;
            tap                   <= '0;
            state                 <= FIR_ACCUMULATE;
          end
        end

        FIR_ACCUMULATE: begin
          // sum wraps at 18 bits
          acc <= acc + product;
          tap <= tap + tap_index_width'(1);
          if (tap == tap_index_width'(fir_taps - 1)) begin
            state <= FIR_EMIT;
          end
        end

        FIR_EMIT: begin
          out_valid  <= 1'b1;
          out_source <= held_source;
          if (filter_on) begin
            // drop the coefficient scaling
            out_data <= acc[acc_width-1:acc_shift];
          end else begin
            out_data <= raw_sample;
          end
          state <= FIR_IDLE;
        end

        default: begin
          state <= FIR_IDLE;
        end
      endcase
    end
  end

  // a strobe during a busy fir is not taken
  always_ff @(posedge clock) begin
    if (state == FIR_IDLE && in.valid) begin
      raw_sample  <= in.data;
      filter_on   <= in.filter;
      held_source <= in.data_source;
    end
  end

endmodule

// File: src/sample_if.sv
`timescale 1ns/1ns

// one tagged sample handed from stage to stage
// valid is a single-cycle strobe, the rest is stable while it is high
interface sample_if
  import audio_pkg::*;
();

  logic           valid;
  sample_t        data;
  // filter enable that rides with this sample
  logic           filter;
  // mic or tone origin of the sample
  sample_source_t data_source;

  // producer side
  modport source (
    output valid, data, filter, data_source
  );

  // consumer side
  modport sink (
    input valid, data, filter, data_source
  );

endinterface

// File: src/tone_source.sv
`timescale 1ns/1ns

// stage 1 of the audio pipeline
// picks mic loopback or the sine tone on every sample strobe
module tone_source
  import audio_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     sample_ready,
  input  sample_t  mic_data,
  input  logic     playback,
  input  logic     filter,
  sample_if.source out
);

  //////////////////////////////////////////////////////////////////////
  // tone index
  //////////////////////////////////////////////////////////////////////

  // position in the sine table
  logic [tone_index_width-1:0] tone_index;
  // table entry at the current position
  sample_t tone_sample;

  assign tone_sample = tone_table[tone_index];

  // index moves on every strobe, also in loopback
  // so the tone phase keeps running while the mic is heard
  always_ff @(posedge clock) begin
    if (reset) begin
      tone_index <= '0;
    end else if (sample_ready) begin
      // wraps at 64 by width
      tone_index <= tone_index + tone_index_width'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // one-cycle strobe, one clock after sample_ready
  always_ff @(posedge clock) begin
    if (reset) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= sample_ready;
    end
  end

  // payload only loads on a strobe
  always_ff @(posedge clock) begin
    if (sample_ready) begin
      if (playback) begin
        out.data        <= tone_sample;
        out.data_source <= SOURCE_TONE;
      end else begin
        out.data        <= mic_data;
        out.data_source <= SOURCE_MIC;
      end
      // captured now so a later switch change misses this sample
      out.filter <= filter;
    end
  end

endmodule

// File: testbench/audio_model.svh
`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model of the audio path
//////////////////////////////////////////////////////////////////////

// one expected result, in strobe order
typedef struct packed {
  int             strobe_edge;
  sample_t        data;
  sample_source_t source;
} expected_t;

// next sine table position, moves on every strobe
int model_tone_index;

// past samples, entry 0 is the newest
sample_t model_history [0:fir_taps-1];

// results still in flight
expected_t expected_q [$];

// back to the power-up state of the DUT
task automatic model_reset();
  model_tone_index = 0;
  for (int k = 0; k < fir_taps; k++) begin
    model_history[k] = '0;
  end
  expected_q.delete();
endtask

// one strobe, returns nothing, queues the expected output
task automatic model_strobe(
  input sample_t mic,
  input logic    play,
  input logic    filt,
  input int      strobe_edge
);
  sample_t        chosen;
  sample_source_t src;
  int             total;
  acc_t           wrapped;
  expected_t      item;
  if (play) begin
    chosen = tone_table[model_tone_index];
    src    = SOURCE_TONE;
  end else begin
    chosen = mic;
    src    = SOURCE_MIC;
  end
  // loopback strobes move the tone too
  model_tone_index = (model_tone_index + 1) % tone_points;
  // every sample enters the history
  for (int k = fir_taps - 1; k > 0; k--) begin
    model_history[k] = model_history[k-1];
  end
  model_history[0] = chosen;
  // full-precision sum, then wrap to the accumulator width
  total = 0;
  for (int k = 0; k < fir_taps; k++) begin
    total += int'(model_history[k]) * int'(fir_coeffs[k]);
  end
  wrapped          = acc_t'(total);
  item.strobe_edge = strobe_edge;
  item.source      = src;
  item.data        = filt ? wrapped[acc_width-1:acc_shift] : chosen;
  expected_q.push_back(item);
endtask

`endif

// File: testbench/audio_pipeline_tb.sv
`timescale 1ns/1ns

// testbench for the audio pipeline
// each strobe gets random mic, playback and filter values and is checked against a model
module audio_pipeline_tb
  import audio_pkg::*;
();

  // run length and limits
  localparam int lfsr_seed       = 42;
  localparam int samples_per_run = 120;
  localparam int reset_cycles    = 4;
  localparam int output_timeout  = pipeline_latency + 5;

  // DUT ports
  logic           clock;
  logic           reset;
  logic           sample_ready;
  sample_t        mic_data;
  logic           playback;
  logic           filter;
  logic           out_valid;
  sample_t        out_data;
  sample_source_t out_source;

  // bookkeeping
  int          cycle_count = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          strobes_sent = 0;
  int          outputs_seen = 0;
  logic        timed_out = 1'b0;
  logic [15:0] lfsr_state;

  `include "audio_model.svh"

  audio_pipeline UUT (
    .clock        (clock),
    .reset        (reset),
    .sample_ready (sample_ready),
    .mic_data     (mic_data),
    .playback     (playback),
    .filter       (filter),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_source   (out_source)
  );

  //////////////////////////////////////////////////////////////////////
  // clock and cycle counter
  //////////////////////////////////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // count of rising edges so far
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // 16-bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end else begin
      return state >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int count, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits       = {bits[6:0], lfsr_state[0]};
    end
  endtask

  // four-state compare so an unknown value never matches
  task automatic check_value(
    input logic signed [31:0] actual,
    input logic signed [31:0] expected,
    input string              what
  );
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // next drive point is 1 ns after the rising edge
  task automatic wait_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic apply_reset();
    reset        = 1'b1;
    sample_ready = 1'b0;
    repeat (reset_cycles) wait_cycle();
    reset = 1'b0;
    model_reset();
    // idle outputs straight after reset
    check_value(out_valid, 0, "out_valid after reset");
    check_value(out_data, 0, "out_data after reset");
  endtask

  // strobes with random content and spacing and a wait for each result
  task automatic run_samples(input int count);
    logic [7:0] bits;
    sample_t    mic;
    logic       play;
    logic       filt;
    int         gap;
    int         waited;
    for (int n = 0; n < count; n++) begin
      take_bits(8, bits);
      mic = sample_t'(bits);
      take_bits(1, bits);
      play = bits[0];
      take_bits(1, bits);
      filt = bits[0];
      take_bits(4, bits);
      // 34 to 45 cycles
      gap = min_strobe_spacing + (int'(bits[3:0]) % 12);
      sample_ready = 1'b1;
      mic_data     = mic;
      playback     = play;
      filter       = filt;
      // sampled on the coming edge
      model_strobe(mic, play, filt, cycle_count + 1);
      strobes_sent++;
      wait_cycle();
      sample_ready = 1'b0;
      waited       = 1;
      while (outputs_seen != strobes_sent && waited < output_timeout) begin
        wait_cycle();
        waited++;
      end
      if (outputs_seen != strobes_sent) begin
        other_errors++;
        timed_out = 1'b1;
        $display("ERROR at %0t: no output arrived for strobe %0d", $time, strobes_sent);
        return;
      end
      while (waited < gap) begin
        wait_cycle();
        waited++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////////////////////////

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    expected_t item;
    if (!reset && out_valid) begin
      outputs_seen++;
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("ERROR at %0t: out_valid is high with no sample in flight", $time);
      end else begin
        item = expected_q.pop_front();
        check_value(cycle_count, item.strobe_edge + pipeline_latency, "out_valid cycle");
        check_value(out_data, item.data, "out_data");
        check_value(out_source, item.source, "out_source");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    sample_ready = 1'b0;
    mic_data     = '0;
    playback     = 1'b0;
    filter       = 1'b0;
    lfsr_state   = 16'(lfsr_seed);
    apply_reset();
    run_samples(samples_per_run);
    // second run checks tone and history restart
    if (!timed_out) begin
      apply_reset();
      run_samples(samples_per_run);
    end
    $display("strobes %0d, outputs %0d, mismatches %0d, other errors %0d",
             strobes_sent, outputs_seen, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && outputs_seen == strobes_sent) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
